/* verification/program.hex */
// one instruction word per line, fetched from address 0 upward
// hex word, then its assembly and byte address
000102b7 // 00 lui   x5, 0x10          io base 0x0001_0000
00000313 // 04 addi  x6, x0, 0         last handled sw
0002a383 // 08 lw    x7, 0(x5)         poll: read switches
fe038ee3 // 0c beq   x7, x0, -4        wait for nonzero
fe638ce3 // 10 beq   x7, x6, -8        wait for a new value
00038313 // 14 addi  x6, x7, 0         remember it
00000513 // 18 addi  x10, x0, 0        sum = 0
00038593 // 1c addi  x11, x7, 0        i = sw
00b50533 // 20 add   x10, x10, x11     loop: sum += i
fff58593 // 24 addi  x11, x11, -1
fe059ce3 // 28 bne   x11, x0, -8
00a2a223 // 2c sw    x10, 4(x5)        led strobe 1
00339613 // 30 slli  x12, x7, 3
0a564613 // 34 xori  x12, x12, 0xa5
00c2a223 // 38 sw    x12, 4(x5)        led strobe 2
04702023 // 3c sw    x7, 64(x0)        save sw to ram
018000ef // 40 jal   x1, +24           call clobber at 0x58
04002383 // 44 lw    x7, 64(x0)        reload sw
00100693 // 48 addi  x13, x0, 1
40d38733 // 4c sub   x14, x7, x13
00e2a223 // 50 sw    x14, 4(x5)        led strobe 3
fb5ff06f // 54 jal   x0, -76           back to poll
00000393 // 58 addi  x7, x0, 0         subroutine wipes x7
00008067 // 5c jalr  x0, 0(x1)         return

/* filelist.f */
common/rv_pkg.sv
hw/core/rv_fetch.sv
hw/core/rv_decode.sv
hw/core/rv_regfile.sv
hw/core/rv_alu.sv
hw/rv_lsu.sv
hw/rv_soc.sv
verification/tb_rv_soc.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module tb_rv_soc -f filelist.f -o sim_tb_rv_soc \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb_rv_soc > sim.log 2>&1
cat sim.log
grep -qx ">>> PASS" sim.log && exit 0 || exit 1

/* verification/tb_rv_soc.sv */
`timescale 1ns/1ps

module tb_rv_soc import rv_pkg::*; ();

    //////////////////////////////////////////////////
    // run length
    //////////////////////////////////////////////////

    localparam int CLK_PERIOD       = 10;   // ns
    localparam int RESET_CYCLES     = 4;
    localparam int NUM_ENTRIES      = 8;
    localparam int CYCLES_PER_ENTRY = 2000; // sum loop for sw = 255 is under 800
    localparam int STROBE_TIMEOUT   = 1500; // cycles allowed for one strobe
    localparam int IDLE_CYCLES      = 200;  // quiet window after each entry
    localparam int BOOT_CYCLES      = 50;   // sw held at 0 after reset
    localparam int WATCHDOG_CYCLES  = NUM_ENTRIES * CYCLES_PER_ENTRY
                                      + RESET_CYCLES + BOOT_CYCLES;

    logic  CLK;
    logic  RESET;
    sw_t   sw_i;
    word_t led_o;
    logic  led_we_o;

    sw_t   sw_tab  [NUM_ENTRIES];
    word_t exp_tab [NUM_ENTRIES][3]; // led values in program order

    int mismatch_cnt;
    int timeout_cnt;
    int strobe_cnt;                  // strobes outside the expected three

    rv_soc u_rv_soc (
        .CLK      (CLK),
        .RESET    (RESET),
        .sw_i     (sw_i),
        .led_o    (led_o),
        .led_we_o (led_we_o)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // expected values, from the program rules
    //////////////////////////////////////////////////

    function automatic word_t triangle_sum(input sw_t v);
        word_t n;
        n = word_t'(v);
        return (n * (n + word_t'(1))) / word_t'(2); // 1 + 2 + .. + sw
    endfunction

    function automatic word_t shift_xor_value(input sw_t v);
        return (word_t'(v) << 3) ^ word_t'(32'h0000_00a5);
    endfunction

    function automatic word_t decrement_value(input sw_t v);
        return word_t'(v) - word_t'(1);
    endfunction

    // new value must be nonzero and differ from the one before, else the core keeps polling
    task automatic build_table();
        sw_t prev;
        sw_t cand;
        prev = '0;                   // core starts with last value 0
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            do begin
                cand = sw_t'($urandom_range(255, 1));
            end while (cand == prev);
            sw_tab[e]     = cand;
            exp_tab[e][0] = triangle_sum(cand);
            exp_tab[e][1] = shift_xor_value(cand);
            exp_tab[e][2] = decrement_value(cand);
            prev          = cand;
            $display("entry %0d sw %02h", e, cand);
        end
    endtask

    //////////////////////////////////////////////////
    // strobe helpers, all sampling on the falling edge
    //////////////////////////////////////////////////

    task automatic wait_strobe(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < STROBE_TIMEOUT) begin
            @(negedge CLK);
            seen = led_we_o;
            n++;
        end
    endtask

    task automatic check_quiet(input int cycles, input string phase);
        repeat (cycles) begin
            @(negedge CLK);
            assert (!led_we_o) else begin
                strobe_cnt++;
                $display("unexpected led_we_o strobe %s at %0t, led_o %08h", phase, $time, led_o);
            end
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatch, %0d timeout, %0d unexpected strobe",
                 mismatch_cnt, timeout_cnt, strobe_cnt);
    endtask

    // watchdog, sized from the entry count
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        timeout_cnt++;
        $display("watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
        report_counts();
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic seen;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        strobe_cnt   = 0;
        RESET        = 1'b1;
        sw_i         = '0;
        void'($urandom(25109));      // single seed for the whole run
        build_table();

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        assert (led_o == '0) else begin
            mismatch_cnt++;
            $display("mismatch led_o after reset: got %08h, expected %08h", led_o, 32'h0);
        end
        check_quiet(BOOT_CYCLES, "before the first entry"); // sw = 0 keeps it polling

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            sw_i = sw_tab[e];        // still on a falling edge here
            for (int s = 0; s < 3; s++) begin
                wait_strobe(seen);
                assert (seen) else begin
                    timeout_cnt++;
                    $display("no led_we_o strobe %0d for entry %0d within %0d cycles",
                             s, e, STROBE_TIMEOUT);
                end
                if (!seen) break;    // core is lost, skip the rest of this entry
                assert (led_o == exp_tab[e][s]) else begin
                    mismatch_cnt++;
                    $display("mismatch led_o entry %0d strobe %0d: got %08h, expected %08h",
                             e, s, led_o, exp_tab[e][s]);
                end
            end
            check_quiet(IDLE_CYCLES, $sformatf("while sw %02h is held", sw_tab[e]));
        end

        report_counts();
        if (mismatch_cnt + timeout_cnt + strobe_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* hw/rv_soc.sv */
`timescale 1ns/1ps

module rv_soc import rv_pkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    input  sw_t   sw_i,
    output word_t led_o,
    output logic  led_we_o
);

    word_t     pc;
    instr_t    instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     imm;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    alu_op_e   alu_op;
    logic      rf_we;
    logic      mem_re;
    logic      mem_we;
    logic      branch;
    logic      jal;
    logic      jalr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;  // address, writeback value
    logic      alu_flag;
    word_t     wb_data;

    //////////////////////////////////////////////////
    // fetch / decode
    //////////////////////////////////////////////////

    rv_fetch u_fetch (
        .CLK        (CLK),
        .RESET      (RESET),
        .branch_i   (branch),
        .jal_i      (jal),
        .jalr_i     (jalr),
        .alu_flag_i (alu_flag),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .pc_o       (pc),
        .instr_o    (instr)
    );

    rv_decode u_decode (
        .instr_i    (instr),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .imm_o      (imm),
        .op_a_sel_o (op_a_sel),
        .op_b_sel_o (op_b_sel),
        .alu_op_o   (alu_op),
        .rf_we_o    (rf_we),
        .mem_re_o   (mem_re),
        .mem_we_o   (mem_we),
        .branch_o   (branch),
        .jal_o      (jal),
        .jalr_o     (jalr)
    );

    //////////////////////////////////////////////////
    // execute / memory / writeback
    //////////////////////////////////////////////////

    rv_regfile u_regfile (
        .CLK        (CLK),
        .RESET      (RESET),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (wb_data),
        .we_i       (rf_we),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu u_alu (
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc),
        .imm_i      (imm),
        .op_a_sel_i (op_a_sel),
        .op_b_sel_i (op_b_sel),
        .alu_op_i   (alu_op),
        .result_o   (alu_result),
        .flag_o     (alu_flag)
    );

    rv_lsu u_lsu (
        .CLK          (CLK),
        .RESET        (RESET),
        .addr_i       (alu_result),
        .wdata_i      (rs2_data),
        .alu_result_i (alu_result),
        .mem_re_i     (mem_re),
        .mem_we_i     (mem_we),
        .sw_i         (sw_i),
        .wb_data_o    (wb_data),
        .led_o        (led_o),
        .led_we_o     (led_we_o)
    );

endmodule

/* hw/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    input  word_t addr_i,       // effective address from the alu
    input  word_t wdata_i,      // rs2 for stores
    input  word_t alu_result_i, // non-load writeback value
    input  logic  mem_re_i,
    input  logic  mem_we_i,
    input  sw_t   sw_i,
    output word_t wb_data_o,
    output word_t led_o,
    output logic  led_we_o
);

    logic                          is_led;
    logic                          is_sw;
    logic [$clog2(DMEM_DEPTH)-1:0] ram_idx;
    word_t                         ram [DMEM_DEPTH];
    word_t                         rdata;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    assign is_led  = (addr_i == IO_LED_ADDR);
    assign is_sw   = (addr_i == IO_SW_ADDR);
    assign ram_idx = addr_i[$clog2(DMEM_DEPTH)+1:2]; // upper bits alias

    // data ram, word writes only
    always_ff @(posedge CLK) begin
        if (mem_we_i && !is_led && !is_sw) begin
            ram[ram_idx] <= wdata_i;
        end
    end

    // led register and one-cycle strobe after the store edge
    always_ff @(posedge CLK) begin
        if (RESET) begin
            led_o    <= '0;
            led_we_o <= 1'b0;
        end else begin
            led_we_o <= mem_we_i && is_led;
            if (mem_we_i && is_led) begin
                led_o <= wdata_i;
            end
        end
    end

    always_comb begin
        if (is_sw) begin
            rdata = {{(XLEN-$bits(sw_t)){1'b0}}, sw_i}; // zero extended, same cycle
        end else if (is_led) begin
            rdata = led_o;
        end else begin
            rdata = ram[ram_idx];
        end
    end

    assign wb_data_o = mem_re_i ? rdata : alu_result_i;

endmodule

/* hw/core/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  word_t     pc_i,
    input  word_t     imm_i,
    input  op_a_sel_e op_a_sel_i,
    input  op_b_sel_e op_b_sel_i,
    input  alu_op_e   alu_op_i,
    output word_t     result_o,
    output logic      flag_o     // branch taken
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    //////////////////////////////////////////////////
    // operand select
    //////////////////////////////////////////////////

    always_comb begin
        case (op_a_sel_i)
            OP_A_RS1: op_a = rs1_data_i;
            OP_A_PC:  op_a = pc_i;
            default:  op_a = '0;   // OP_A_ZERO
        endcase
        case (op_b_sel_i)
            OP_B_RS2:  op_b = rs2_data_i;
            OP_B_IMM:  op_b = imm_i;
            OP_B_FOUR: op_b = word_t'(4);
            default:   op_b = '0;
        endcase
    end

    assign shamt = op_b[4:0];
    assign eq    = (op_a == op_b);
    assign lt_s  = ($signed(op_a) < $signed(op_b));
    assign lt_u  = (op_a < op_b);

    always_comb begin
        result_o = '0;
        flag_o   = 1'b0;
        case (alu_op_i)
            ALU_ADD:  result_o = op_a + op_b;
            ALU_SUB:  result_o = op_a - op_b;
            ALU_SLL:  result_o = op_a << shamt;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result_o = op_a ^ op_b;
            ALU_SRL:  result_o = op_a >> shamt;
            ALU_SRA:  result_o = word_t'($signed(op_a) >>> shamt); // keeps sign
            ALU_OR:   result_o = op_a | op_b;
            ALU_AND:  result_o = op_a & op_b;
            ALU_EQ:   flag_o   = eq;
            ALU_NE:   flag_o   = !eq;
            ALU_LT:   flag_o   = lt_s;
            ALU_GE:   flag_o   = !lt_s;
            ALU_LTU:  flag_o   = lt_u;
            ALU_GEU:  flag_o   = !lt_u;
        endcase
    end

endmodule

/* hw/core/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     rd_data_i,
    input  logic      we_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs [32];

    // async reads, x0 never gets written so it reads as zero
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

endmodule

/* hw/core/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  instr_t    instr_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output reg_addr_t rd_addr_o,
    output word_t     imm_o,
    output op_a_sel_e op_a_sel_o,
    output op_b_sel_e op_b_sel_o,
    output alu_op_e   alu_op_o,
    output logic      rf_we_o,
    output logic      mem_re_o,
    output logic      mem_we_o,
    output logic      branch_o,
    output logic      jal_o,
    output logic      jalr_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;  // sub / sra select
    word_t      imm_i_type;
    word_t      imm_s_type;
    word_t      imm_b_type;
    word_t      imm_u_type;
    word_t      imm_j_type;

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr_o  = instr_i[11:7];

    //////////////////////////////////////////////////
    // immediates, all sign extended from bit 31
    //////////////////////////////////////////////////

    assign imm_i_type = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s_type = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    //////////////////////////////////////////////////
    // main decoder
    //////////////////////////////////////////////////

    always_comb begin
        // no-op unless an opcode below claims the instruction
        imm_o      = imm_i_type;
        op_a_sel_o = OP_A_RS1;
        op_b_sel_o = OP_B_IMM;
        alu_op_o   = ALU_ADD;
        rf_we_o    = 1'b0;
        mem_re_o   = 1'b0;
        mem_we_o   = 1'b0;
        branch_o   = 1'b0;
        jal_o      = 1'b0;
        jalr_o     = 1'b0;
        case (opcode)
            OPC_LUI: begin
                imm_o      = imm_u_type;
                op_a_sel_o = OP_A_ZERO; // 0 + imm
                rf_we_o    = 1'b1;
            end
            OPC_AUIPC: begin
                imm_o      = imm_u_type;
                op_a_sel_o = OP_A_PC;
                rf_we_o    = 1'b1;
            end
            OPC_JAL: begin
                imm_o      = imm_j_type;   // target offset for fetch
                op_a_sel_o = OP_A_PC;
                op_b_sel_o = OP_B_FOUR;    // link value
                rf_we_o    = 1'b1;
                jal_o      = 1'b1;
            end
            OPC_JALR: begin
                op_a_sel_o = OP_A_PC;      // fetch adds rs1 + imm itself
                op_b_sel_o = OP_B_FOUR;
                rf_we_o    = 1'b1;
                jalr_o     = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o      = imm_b_type;
                op_b_sel_o = OP_B_RS2;
                branch_o   = 1'b1;
                case (funct3)
                    3'b000:  alu_op_o = ALU_EQ;
                    3'b001:  alu_op_o = ALU_NE;
                    3'b100:  alu_op_o = ALU_LT;
                    3'b101:  alu_op_o = ALU_GE;
                    3'b110:  alu_op_o = ALU_LTU;
                    3'b111:  alu_op_o = ALU_GEU;
                    default: branch_o = 1'b0; // reserved funct3, fall through
                endcase
            end
            OPC_LOAD: begin
                rf_we_o  = 1'b1;           // lw only, funct3 not checked
                mem_re_o = 1'b1;
            end
            OPC_STORE: begin
                imm_o    = imm_s_type;
                mem_we_o = 1'b1;
            end
            OPC_OP_IMM: begin
                // funct7 only matters for srai, addi has no subi
                alu_op_o = alu_op_e'({funct7_b5 && (funct3 == 3'b101), funct3});
                rf_we_o  = 1'b1;
            end
            OPC_OP: begin
                op_b_sel_o = OP_B_RS2;
                alu_op_o   = alu_op_e'({funct7_b5 && (funct3 == 3'b000 || funct3 == 3'b101),
                                        funct3});
                rf_we_o    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hw/core/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  logic   branch_i,   // conditional branch in this cycle
    input  logic   jal_i,
    input  logic   jalr_i,
    input  logic   alu_flag_i, // branch condition from the alu
    input  word_t  imm_i,      // B, J or I immediate from decode
    input  word_t  rs1_data_i, // base register for jalr
    output word_t  pc_o,
    output instr_t instr_o
);

    word_t  pc_q;
    word_t  pc_next;
    word_t  pc_plus4;
    word_t  pc_rel;      // branch / jal target
    word_t  jalr_sum;
    instr_t rom [IMEM_DEPTH];

    initial begin
        $readmemh(IMEM_FILE, rom);
    end

    // word index, bits 1:0 are always zero for aligned fetch
    assign instr_o = rom[pc_q[$clog2(IMEM_DEPTH)+1:2]];
    assign pc_o    = pc_q;

    assign pc_plus4 = pc_q + word_t'(4);
    assign pc_rel   = pc_q + imm_i;
    assign jalr_sum = rs1_data_i + imm_i;

    always_comb begin
        if (jalr_i) begin
            pc_next = {jalr_sum[XLEN-1:1], 1'b0}; // RV32I clears bit 0
        end else if (jal_i || (branch_i && alu_flag_i)) begin
            pc_next = pc_rel;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next; // one instruction retires per edge
        end
    end

endmodule

/* common/rv_pkg.sv */
package rv_pkg;

    //////////////////////////////////////////////////
    // widths and vector types
    //////////////////////////////////////////////////

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;     // data and byte address
    typedef logic [31:0]     instr_t;    // raw instruction word
    typedef logic [4:0]      reg_addr_t; // x0..x31
    typedef logic [7:0]      sw_t;       // board switches

    //////////////////////////////////////////////////
    // memory map and boot
    //////////////////////////////////////////////////

    localparam int    IMEM_DEPTH  = 256;           // words
    localparam int    DMEM_DEPTH  = 256;           // words
    localparam word_t IO_SW_ADDR  = 32'h0001_0000; // read only
    localparam word_t IO_LED_ADDR = 32'h0001_0004; // write, reads back
    localparam word_t RESET_PC    = 32'h0000_0000;
    localparam string IMEM_FILE   = "verification/program.hex";

    // major opcodes, instr[6:0]; anything else runs as a no-op
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // low half is {funct7[5], funct3} of the arithmetic group,
    // comparisons fill the free codes and only drive the flag
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_EQ   = 4'b1001,
        ALU_NE   = 4'b1010,
        ALU_LT   = 4'b1011,
        ALU_GE   = 4'b1100,
        ALU_SRA  = 4'b1101,
        ALU_LTU  = 4'b1110,
        ALU_GEU  = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        OP_A_RS1  = 2'd0,
        OP_A_PC   = 2'd1,
        OP_A_ZERO = 2'd2 // lui
    } op_a_sel_e;

    typedef enum logic [1:0] {
        OP_B_RS2  = 2'd0,
        OP_B_IMM  = 2'd1,
        OP_B_FOUR = 2'd2 // link address pc + 4
    } op_b_sel_e;

endpackage
